// ==== rtl/dtrans_pkg.sv ====
package dtrans_pkg;

    // --------------------------------------------------
    // csr addresses
    // --------------------------------------------------
    localparam logic [13:0] CSR_CRMD = 14'h000;
    localparam logic [13:0] CSR_DMW0 = 14'h180;
    localparam logic [13:0] CSR_DMW1 = 14'h181;

    // --------------------------------------------------
    // csr word layouts
    // --------------------------------------------------

    // direct-mapped window, one per dmw register.
    typedef struct packed {
        logic [2:0]  vseg;
        logic        rsvd_28;
        logic [2:0]  pseg;
        logic [20:0] rsvd_24_4;
        logic        plv3;
        logic [1:0]  rsvd_2_1;
        logic        plv0;
    } dmw_word_t;

    // only plv and da matter for data-side translation.
    typedef struct packed {
        logic [27:0] rsvd_31_4;
        logic        da;
        logic        rsvd_2;
        logic [1:0]  plv;
    } crmd_word_t;

    // the csr address picks which view of the write word is meaningful.
    typedef union packed {
        dmw_word_t  dmw;
        crmd_word_t crmd;
    } csr_wdata_u;

    // --------------------------------------------------
    // result source
    // --------------------------------------------------

    // a miss is reported with SRC_TLB, since the tlb is the last path tried.
    typedef enum logic [1:0] {
        SRC_DA   = 2'd0,
        SRC_DMW0 = 2'd1,
        SRC_DMW1 = 2'd2,
        SRC_TLB  = 2'd3
    } trans_src_e;

endpackage

// ==== rtl/csr_view_if.sv ====
`timescale 1ns/1ns

// translation state as seen by the lookups and the combiner.
interface csr_view_if;

    logic [1:0]            plv;
    logic                  da;
    dtrans_pkg::dmw_word_t dmw0;
    dtrans_pkg::dmw_word_t dmw1;

    // owned by the csr block.
    modport src (
        output plv,
        output da,
        output dmw0,
        output dmw1
    );

    modport dst (
        input plv,
        input da,
        input dmw0,
        input dmw1
    );

endinterface

// ==== rtl/trans_csr_regs.sv ====
`timescale 1ns/1ns

module trans_csr_regs (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        csr_we_i,
    input  logic [13:0] csr_addr_i,
    input  logic [31:0] csr_wdata_i,
    csr_view_if.src     csr_o
);

    dtrans_pkg::csr_wdata_u wdata;
    logic [1:0]             plv_q;
    logic                   da_q;
    dtrans_pkg::dmw_word_t  dmw0_q;
    dtrans_pkg::dmw_word_t  dmw1_q;
    logic                   dmw_live;

    // reserved bits of a window read back as zero.
    function automatic dtrans_pkg::dmw_word_t keep_dmw_fields(input dtrans_pkg::dmw_word_t w);
        dtrans_pkg::dmw_word_t r;
        r      = '0;
        r.vseg = w.vseg;
        r.pseg = w.pseg;
        r.plv3 = w.plv3;
        r.plv0 = w.plv0;
        return r;
    endfunction

    assign wdata = csr_wdata_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            plv_q  <= 2'd0;
            da_q   <= 1'b1;
            dmw0_q <= '0;
            dmw1_q <= '0;
        end else if (csr_we_i) begin
            case (csr_addr_i)
                dtrans_pkg::CSR_CRMD: begin
                    plv_q <= wdata.crmd.plv;
                    da_q  <= wdata.crmd.da;
                end
                dtrans_pkg::CSR_DMW0: dmw0_q <= keep_dmw_fields(wdata.dmw);
                dtrans_pkg::CSR_DMW1: dmw1_q <= keep_dmw_fields(wdata.dmw);
                default: ;
            endcase
        end
    end

    assign csr_o.plv  = plv_q;
    assign csr_o.da   = da_q;
    assign csr_o.dmw0 = dmw0_q;
    assign csr_o.dmw1 = dmw1_q;

    // a window can only match at plv 0 or 3, so the middle levels would silently miss.
    assign dmw_live = dmw0_q.plv0 | dmw0_q.plv3 | dmw1_q.plv0 | dmw1_q.plv3;

    a_plv_for_dmw: assert property (
        @(posedge clk) disable iff (!rst_n)
        (!da_q && dmw_live) |-> (plv_q == 2'd0 || plv_q == 2'd3)
    ) else $error("plv %0d while a dmw window is in use", plv_q);

endmodule

// ==== rtl/dmw_matcher.sv ====
`timescale 1ns/1ns

module dmw_matcher (
    input  logic [2:0] vaddr_seg_i,
    csr_view_if.dst    csr_i,
    output logic       dmw0_hit_o,
    output logic       dmw1_hit_o
);

    logic plv_is_0;
    logic plv_is_3;

    // --------------------------------------------------
    // window rule
    // --------------------------------------------------

    // the privilege check and the segment compare must both pass.
    function automatic logic window_hit(
        input dtrans_pkg::dmw_word_t w,
        input logic                  at_plv0,
        input logic                  at_plv3,
        input logic [2:0]            seg
    );
        logic plv_ok;
        plv_ok = (w.plv0 && at_plv0) || (w.plv3 && at_plv3);
        return plv_ok && (seg == w.vseg);
    endfunction

    assign plv_is_0 = (csr_i.plv == 2'd0);
    assign plv_is_3 = (csr_i.plv == 2'd3);

    // both windows are checked in parallel.
    // priority between them is left to the combiner.
    assign dmw0_hit_o = window_hit(csr_i.dmw0, plv_is_0, plv_is_3, vaddr_seg_i);
    assign dmw1_hit_o = window_hit(csr_i.dmw1, plv_is_0, plv_is_3, vaddr_seg_i);

endmodule

// ==== rtl/tlb_lookup.sv ====
`timescale 1ns/1ns

module tlb_lookup #(
    parameter int TLB_ENTRIES = 8
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           we_i,
    input  logic [$clog2(TLB_ENTRIES)-1:0] idx_i,
    input  logic [19:0]                    vppn_i,
    input  logic [19:0]                    ppn_i,
    input  logic                           inv_i,
    input  logic [19:0]                    lookup_vppn_i,
    output logic                           hit_o,
    output logic [19:0]                    ppn_o
);

    logic [TLB_ENTRIES-1:0] valid_q;
    logic [19:0]            vppn_q [TLB_ENTRIES];
    logic [19:0]            ppn_q  [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0] hit_vec;

    // --------------------------------------------------
    // entry storage
    // --------------------------------------------------

    // an invalidate pulse wins over a write in the same cycle.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (inv_i) begin
            valid_q <= '0;
        end else if (we_i) begin
            valid_q[idx_i] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (we_i) begin
            vppn_q[idx_i] <= vppn_i;
            ppn_q[idx_i]  <= ppn_i;
        end
    end

    // --------------------------------------------------
    // lookup
    // --------------------------------------------------
    always_comb begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            hit_vec[i] = valid_q[i] && (vppn_q[i] == lookup_vppn_i);
        end
    end

    // at most one entry matches, so or-ing the masked ppns gives the hit entry.
    always_comb begin
        ppn_o = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (hit_vec[i]) begin
                ppn_o = ppn_o | ppn_q[i];
            end
        end
    end

    assign hit_o = |hit_vec;

    // two live entries with the same vppn come from a bad fill sequence.
    a_single_hit: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(hit_vec)
    ) else $error("tlb lookup %h matched entries %b", lookup_vppn_i, hit_vec);

endmodule

// ==== rtl/trans_select.sv ====
`timescale 1ns/1ns

module trans_select #(
    parameter bit SUPPORT_32_PADDR = 1'b1
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    valid_i,
    input  logic [31:0]             vaddr_i,
    input  logic                    stall_i,
    csr_view_if.dst                 csr_i,
    input  logic                    dmw0_hit_i,
    input  logic                    dmw1_hit_i,
    input  logic                    tlb_hit_i,
    input  logic [19:0]             tlb_ppn_i,
    output logic                    valid_o,
    output logic [31:0]             paddr_o,
    output logic                    miss_o,
    output dtrans_pkg::trans_src_e  src_o
);

    logic [2:0]             dmw0_top;
    logic [2:0]             dmw1_top;
    logic [31:0]            paddr_d;
    logic                   miss_d;
    dtrans_pkg::trans_src_e src_d;

    // without a full 32-bit physical space the window lands in the low 512 MB.
    assign dmw0_top = SUPPORT_32_PADDR ? csr_i.dmw0.pseg : 3'b000;
    assign dmw1_top = SUPPORT_32_PADDR ? csr_i.dmw1.pseg : 3'b000;

    // --------------------------------------------------
    // priority from da down to dmw0, dmw1 and the tlb
    // --------------------------------------------------
    always_comb begin
        src_d   = dtrans_pkg::SRC_TLB;
        paddr_d = '0;
        miss_d  = 1'b0;
        if (csr_i.da) begin
            src_d   = dtrans_pkg::SRC_DA;
            paddr_d = vaddr_i;
        end else if (dmw0_hit_i) begin
            src_d   = dtrans_pkg::SRC_DMW0;
            paddr_d = {dmw0_top, vaddr_i[28:0]};
        end else if (dmw1_hit_i) begin
            src_d   = dtrans_pkg::SRC_DMW1;
            paddr_d = {dmw1_top, vaddr_i[28:0]};
        end else if (tlb_hit_i) begin
            paddr_d = {tlb_ppn_i, vaddr_i[11:0]};
        end else begin
            miss_d = 1'b1;
        end
    end

    // m1 register.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_o <= 1'b0;
            paddr_o <= '0;
            miss_o  <= 1'b0;
            src_o   <= dtrans_pkg::SRC_DA;
        end else if (!stall_i) begin
            valid_o <= valid_i;
            paddr_o <= paddr_d;
            miss_o  <= valid_i && miss_d;
            src_o   <= src_d;
        end
    end

    a_stall_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        stall_i |=> $stable({valid_o, paddr_o, miss_o, src_o})
    ) else $error("m1 outputs changed under stall");

endmodule

// ==== rtl/dtrans_top.sv ====
`timescale 1ns/1ns

module dtrans_top #(
    parameter int TLB_ENTRIES      = 8,
    parameter bit SUPPORT_32_PADDR = 1'b1
) (
    input  logic                           clk,
    input  logic                           rst_n,

    // request from the address stage.
    input  logic                           valid_i,
    input  logic [31:0]                    vaddr_i,
    input  logic                           stall_i,

    input  logic                           csr_we_i,
    input  logic [13:0]                    csr_addr_i,
    input  logic [31:0]                    csr_wdata_i,

    input  logic                           tlb_we_i,
    input  logic [$clog2(TLB_ENTRIES)-1:0] tlb_idx_i,
    input  logic [19:0]                    tlb_vppn_i,
    input  logic [19:0]                    tlb_ppn_i,
    input  logic                           tlb_inv_i,

    // result in m1.
    output logic                           valid_o,
    output logic [31:0]                    paddr_o,
    output logic                           miss_o,
    output dtrans_pkg::trans_src_e         src_o
);

    csr_view_if csr_view ();

    logic        dmw0_hit;
    logic        dmw1_hit;
    logic        tlb_hit;
    logic [19:0] tlb_ppn;

    trans_csr_regs u_csr (
        .clk         (clk),
        .rst_n       (rst_n),
        .csr_we_i    (csr_we_i),
        .csr_addr_i  (csr_addr_i),
        .csr_wdata_i (csr_wdata_i),
        .csr_o       (csr_view.src)
    );

    // --------------------------------------------------
    // parallel lookups
    // --------------------------------------------------
    dmw_matcher u_dmw (
        .vaddr_seg_i (vaddr_i[31:29]),
        .csr_i       (csr_view.dst),
        .dmw0_hit_o  (dmw0_hit),
        .dmw1_hit_o  (dmw1_hit)
    );

    tlb_lookup #(
        .TLB_ENTRIES (TLB_ENTRIES)
    ) u_tlb (
        .clk           (clk),
        .rst_n         (rst_n),
        .we_i          (tlb_we_i),
        .idx_i         (tlb_idx_i),
        .vppn_i        (tlb_vppn_i),
        .ppn_i         (tlb_ppn_i),
        .inv_i         (tlb_inv_i),
        .lookup_vppn_i (vaddr_i[31:12]),
        .hit_o         (tlb_hit),
        .ppn_o         (tlb_ppn)
    );

    trans_select #(
        .SUPPORT_32_PADDR (SUPPORT_32_PADDR)
    ) u_select (
        .clk        (clk),
        .rst_n      (rst_n),
        .valid_i    (valid_i),
        .vaddr_i    (vaddr_i),
        .stall_i    (stall_i),
        .csr_i      (csr_view.dst),
        .dmw0_hit_i (dmw0_hit),
        .dmw1_hit_i (dmw1_hit),
        .tlb_hit_i  (tlb_hit),
        .tlb_ppn_i  (tlb_ppn),
        .valid_o    (valid_o),
        .paddr_o    (paddr_o),
        .miss_o     (miss_o),
        .src_o      (src_o)
    );

endmodule

// ==== dv/dtrans_tb.sv ====
`timescale 1ns/1ns

module dtrans_tb;

    typedef enum int {OP_CSR, OP_TLBW, OP_INV, OP_LOOK, OP_STALL} op_e;

    localparam int MAX_STEPS = 32;

    logic clk = 1'b0;
    logic rst_n;
    logic valid_i;
    logic [31:0] vaddr_i;
    logic stall_i;
    logic csr_we_i;
    logic [13:0] csr_addr_i;
    logic [31:0] csr_wdata_i;
    logic tlb_we_i;
    logic [2:0] tlb_idx_i;
    logic [19:0] tlb_vppn_i;
    logic [19:0] tlb_ppn_i;
    logic tlb_inv_i;
    logic valid_o;
    logic [31:0] paddr_o;
    logic miss_o;
    dtrans_pkg::trans_src_e src_o;

    // a holds the csr address, tlb index or vaddr; b the csr data or vppn; c the ppn.
    op_e step_op [MAX_STEPS];
    logic [31:0] step_a [MAX_STEPS];
    logic [31:0] step_b [MAX_STEPS];
    logic [19:0] step_c [MAX_STEPS];
    logic [31:0] exp_paddr [MAX_STEPS];
    logic exp_miss [MAX_STEPS];
    dtrans_pkg::trans_src_e exp_src [MAX_STEPS];
    int n_steps;

    // reference copy of the translation state.
    logic [1:0] m_plv;
    logic m_da;
    logic [31:0] m_dmw0;
    logic [31:0] m_dmw1;
    logic m_valid [8];
    logic [19:0] m_vppn [8];
    logic [19:0] m_ppn [8];

    logic [31:0] held_paddr;
    logic held_miss;
    dtrans_pkg::trans_src_e held_src;
    int cycles = 0;
    int cycle_limit;

    dtrans_top dut_i (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("run stopped: the table did not finish within %0d cycles", cycle_limit);
            $display("Errors found");
            $fatal(1, "timeout");
        end
    end

    // --------------------------------------------------
    // reference model
    // --------------------------------------------------
    function automatic logic window_match(input logic [31:0] w, input logic [2:0] seg);
        logic plv_ok;
        plv_ok = (w[0] && m_plv == 2'd0) || (w[3] && m_plv == 2'd3);
        return plv_ok && (w[31:29] == seg);
    endfunction

    task automatic predict(input logic [31:0] va, output logic [31:0] pa, output logic miss,
                           output dtrans_pkg::trans_src_e src);
        int hit_idx;
        hit_idx = -1;
        for (int i = 0; i < 8; i++) begin
            if (m_valid[i] && m_vppn[i] == va[31:12]) hit_idx = i;
        end
        pa   = '0;
        miss = 1'b0;
        src  = dtrans_pkg::SRC_TLB;
        if (m_da) begin
            src = dtrans_pkg::SRC_DA;
            pa  = va;
        end else if (window_match(m_dmw0, va[31:29])) begin
            src = dtrans_pkg::SRC_DMW0;
            pa  = {m_dmw0[27:25], va[28:0]};
        end else if (window_match(m_dmw1, va[31:29])) begin
            src = dtrans_pkg::SRC_DMW1;
            pa  = {m_dmw1[27:25], va[28:0]};
        end else if (hit_idx >= 0) begin
            pa = {m_ppn[hit_idx], va[11:0]};
        end else begin
            miss = 1'b1;
        end
    endtask

    // --------------------------------------------------
    // table construction
    // --------------------------------------------------
    task automatic add_csr(input logic [13:0] addr, input logic [31:0] data);
        step_op[n_steps] = OP_CSR;
        step_a[n_steps]  = {18'd0, addr};
        step_b[n_steps]  = data;
        case (addr)
            dtrans_pkg::CSR_CRMD: begin
                m_plv = data[1:0];
                m_da  = data[3];
            end
            dtrans_pkg::CSR_DMW0: m_dmw0 = data;
            dtrans_pkg::CSR_DMW1: m_dmw1 = data;
            default: ;
        endcase
        n_steps++;
    endtask

    task automatic add_tlb(input int idx, input logic [19:0] vppn, input logic [19:0] ppn);
        step_op[n_steps] = OP_TLBW;
        step_a[n_steps]  = 32'(idx);
        step_b[n_steps]  = {12'd0, vppn};
        step_c[n_steps]  = ppn;
        m_valid[idx] = 1'b1;
        m_vppn[idx]  = vppn;
        m_ppn[idx]   = ppn;
        n_steps++;
    endtask

    task automatic add_inv();
        step_op[n_steps] = OP_INV;
        for (int i = 0; i < 8; i++) m_valid[i] = 1'b0;
        n_steps++;
    endtask

    // the page offset is random, the page itself is chosen.
    task automatic add_look(input op_e op, input logic [31:0] page);
        logic [31:0] va;
        va = (page & 32'hFFFF_F000) | ($urandom & 32'h0000_0FFF);
        step_op[n_steps] = op;
        step_a[n_steps]  = va;
        predict(va, exp_paddr[n_steps], exp_miss[n_steps], exp_src[n_steps]);
        n_steps++;
    endtask

    task automatic build_table();
        n_steps = 0;
        m_plv   = 2'd0;
        m_da    = 1'b1;
        m_dmw0  = '0;
        m_dmw1  = '0;
        for (int i = 0; i < 8; i++) m_valid[i] = 1'b0;
        add_look(OP_LOOK, 32'h1234_5000);
        add_csr(dtrans_pkg::CSR_DMW0, 32'hA200_0001);
        add_csr(dtrans_pkg::CSR_DMW1, 32'hA400_0009);
        add_csr(dtrans_pkg::CSR_CRMD, 32'h0000_0000);
        add_look(OP_LOOK, 32'hA000_0000);
        // window 0 moves to segment 4 and is enabled for plv 3 only.
        add_csr(dtrans_pkg::CSR_DMW0, 32'h8C00_0008);
        add_look(OP_LOOK, 32'hA000_0000);
        add_look(OP_LOOK, 32'h8000_0000);
        add_csr(dtrans_pkg::CSR_CRMD, 32'h0000_0003);
        add_look(OP_LOOK, 32'h8000_0000);
        add_csr(dtrans_pkg::CSR_CRMD, 32'h0000_0000);
        add_csr(14'h001, 32'hFFFF_FFFF);
        add_tlb(2, 20'h00403, 20'h1F0A2);
        add_tlb(5, 20'h7FFFF, 20'h00011);
        add_look(OP_LOOK, 32'h0040_3000);
        add_look(OP_LOOK, 32'h7FFF_F000);
        add_look(OP_LOOK, 32'h0040_4000);
        add_look(OP_STALL, 32'h7FFF_F000);
        add_inv();
        add_look(OP_LOOK, 32'h0040_3000);
        add_look(OP_STALL, 32'hA000_0000);
        add_csr(dtrans_pkg::CSR_CRMD, 32'h0000_0008);
        add_look(OP_LOOK, 32'hFFFF_F000);
        add_look(OP_STALL, 32'h0040_3000);
    endtask

    // --------------------------------------------------
    // checks and stimulus
    // --------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        assert (got == want) else begin
            $display("** Error: %s = %h, expected %h", name, got, want);
            $display("Errors found");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_outputs(input logic [31:0] pa, input logic miss,
                                 input dtrans_pkg::trans_src_e src);
        check_value("valid_o", 32'(valid_o), 32'd1);
        check_value("paddr_o", paddr_o, pa);
        check_value("miss_o", 32'(miss_o), 32'(miss));
        check_value("src_o", 32'(src_o), 32'(src));
    endtask

    task automatic clear_inputs();
        valid_i     = 1'b0;
        vaddr_i     = '0;
        stall_i     = 1'b0;
        csr_we_i    = 1'b0;
        csr_addr_i  = '0;
        csr_wdata_i = '0;
        tlb_we_i    = 1'b0;
        tlb_idx_i   = '0;
        tlb_vppn_i  = '0;
        tlb_ppn_i   = '0;
        tlb_inv_i   = 1'b0;
    endtask

    // a stalled step always follows a lookup, so the held values are known.
    task automatic run_step(input int i);
        case (step_op[i])
            OP_CSR: begin
                csr_we_i    = 1'b1;
                csr_addr_i  = step_a[i][13:0];
                csr_wdata_i = step_b[i];
            end
            OP_TLBW: begin
                tlb_we_i   = 1'b1;
                tlb_idx_i  = step_a[i][2:0];
                tlb_vppn_i = step_b[i][19:0];
                tlb_ppn_i  = step_c[i];
            end
            OP_INV: tlb_inv_i = 1'b1;
            OP_LOOK: begin
                valid_i = 1'b1;
                vaddr_i = step_a[i];
            end
            OP_STALL: begin
                valid_i = 1'b1;
                vaddr_i = step_a[i];
                stall_i = 1'b1;
                repeat (2) begin
                    @(negedge clk);
                    check_outputs(held_paddr, held_miss, held_src);
                end
                stall_i = 1'b0;
            end
        endcase
        @(negedge clk);
        if (step_op[i] == OP_LOOK || step_op[i] == OP_STALL) begin
            check_outputs(exp_paddr[i], exp_miss[i], exp_src[i]);
            held_paddr = exp_paddr[i];
            held_miss  = exp_miss[i];
            held_src   = exp_src[i];
        end
        clear_inputs();
    endtask

    initial begin
        void'($urandom(32'h289));
        rst_n = 1'b0;
        clear_inputs();
        build_table();
        cycle_limit = n_steps * 4 + 20;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        check_value("valid_o", 32'(valid_o), 32'd0);
        check_value("miss_o", 32'(miss_o), 32'd0);
        for (int i = 0; i < n_steps; i++) begin
            run_step(i);
        end
        $display("No errors");
        $finish;
    end

endmodule

// ==== verilog.f ====
rtl/dtrans_pkg.sv
rtl/csr_view_if.sv
rtl/trans_csr_regs.sv
rtl/dmw_matcher.sv
rtl/tlb_lookup.sv
rtl/trans_select.sv
rtl/dtrans_top.sv
dv/dtrans_tb.sv

// ==== Makefile ====
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f verilog.f --top-module dtrans_top
	verilator --lint-only --timing --assert -f verilog.f --top-module dtrans_tb

sim:
	verilator --binary --timing --assert -f verilog.f --top-module dtrans_tb -o sim_dtrans
	./obj_dir/sim_dtrans | tee sim.log
	grep -q "^No errors$$" sim.log

clean:
	rm -rf obj_dir sim.log
